//--- logic/debugPkg.sv
package debugPkg;

    // ======================================================================
    // Link and queue sizes
    // ======================================================================

    // One link byte, also the FIFO word
    localparam int ByteWidth = 8;

    // Bytes still to send in a reply, command byte included
    localparam int MsgLenWidth = 9;

    // Eight entries per FIFO
    localparam int FifoDepthLog2 = 3;

    // ======================================================================
    // Command codes
    // ======================================================================

    // Poll byte, dropped at the link and never queued
    localparam logic [ByteWidth-1:0] CmdNop = 8'h00;
    localparam logic [ByteWidth-1:0] CmdLedOff = 8'h80;
    localparam logic [ByteWidth-1:0] CmdLedOn = 8'h81;
    localparam logic [ByteWidth-1:0] CmdReadMem = 8'h82;

    // Payload length of a ReadMem reply
    localparam int ReadMemBytes = 16;

endpackage

//--- logic/byteQueueIf.sv
`timescale 1ns/1ns

interface byteQueueIf import debugPkg::*; ();

    // Writer side
    // Clock comes from the FIFO instance
    logic wrClk;
    logic [ByteWidth-1:0] wrData;
    logic wr;
    // Not full
    logic wrOk;

    // Reader side
    // Clock comes from the reading module
    logic rdClk;
    logic [ByteWidth-1:0] rdData;
    logic rd;
    // Head entry valid
    logic rdOk;

    modport writer (
        input wrClk,
        input wrOk,
        output wrData,
        output wr
    );

    modport reader (
        input rdData,
        input rdOk,
        output rdClk,
        output rd
    );

endinterface

//--- logic/asyncByteFifo.sv
`timescale 1ns/1ns

module asyncByteFifo import debugPkg::*; (
    input logic clk,
    input logic rst,
    input logic debugRst,
    byteQueueIf port
);

    // Storage
    logic [ByteWidth-1:0] mem [2**FifoDepthLog2];

    // Write domain, extra top bit tells laps apart
    logic [FifoDepthLog2:0] wrBin;
    logic [FifoDepthLog2:0] wrBinNext;
    logic [FifoDepthLog2:0] wrGray;
    logic [FifoDepthLog2:0] rdGraySync1;
    logic [FifoDepthLog2:0] rdGraySync2;
    logic wrEn;

    // Read domain
    logic [FifoDepthLog2:0] rdBin;
    logic [FifoDepthLog2:0] rdBinNext;
    logic [FifoDepthLog2:0] rdGray;
    logic [FifoDepthLog2:0] wrGraySync1;
    logic [FifoDepthLog2:0] wrGraySync2;
    logic rdEn;

    function automatic logic [FifoDepthLog2:0] toGray(input logic [FifoDepthLog2:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // ======================================================================
    // Write side, clocked by clk and cleared by rst
    // ======================================================================

    // Writer side sees its clock through the interface
    assign port.wrClk = clk;

    // Full when the two top Gray bits are inverted and the rest match
    assign port.wrOk = (wrGray != {~rdGraySync2[FifoDepthLog2 -: 2],
                                   rdGraySync2[FifoDepthLog2-2:0]});
    assign wrEn = port.wr && port.wrOk;
    assign wrBinNext = wrBin + 1'b1;

    always_ff @(posedge port.wrClk) begin
        if (wrEn) begin
            mem[wrBin[FifoDepthLog2-1:0]] <= port.wrData;
        end
    end

    always_ff @(posedge port.wrClk) begin
        if (rst) begin
            wrBin <= '0;
            wrGray <= '0;
            rdGraySync1 <= '0;
            rdGraySync2 <= '0;
        end else begin
            if (wrEn) begin
                wrBin <= wrBinNext;
                wrGray <= toGray(wrBinNext);
            end
            // Read pointer into the write clock
            rdGraySync1 <= rdGray;
            rdGraySync2 <= rdGraySync1;
        end
    end

    // ======================================================================
    // Read side, clocked by the reader and cleared by debugRst
    // ======================================================================

    // Empty when both Gray pointers match
    assign port.rdOk = (rdGray != wrGraySync2);
    // Head entry shown directly
    assign port.rdData = mem[rdBin[FifoDepthLog2-1:0]];
    assign rdEn = port.rd && port.rdOk;
    assign rdBinNext = rdBin + 1'b1;

    always_ff @(posedge port.rdClk) begin
        if (debugRst) begin
            rdBin <= '0;
            rdGray <= '0;
            wrGraySync1 <= '0;
            wrGraySync2 <= '0;
        end else begin
            if (rdEn) begin
                rdBin <= rdBinNext;
                rdGray <= toGray(rdBinNext);
            end
            // Write pointer into the read clock
            wrGraySync1 <= wrGray;
            wrGraySync2 <= wrGraySync1;
        end
    end

endmodule

//--- logic/serialLink.sv
`timescale 1ns/1ns

module serialLink import debugPkg::*; (
    input logic debugClk,
    input logic debugRst,
    input logic debugCs,
    input logic debugDi,
    output logic debugDo,
    byteQueueIf.writer cmdQueue,
    byteQueueIf.reader replyQueue
);

    // Receive shifter, top bit is the sentinel
    logic [ByteWidth:0] rxShift;
    logic rxDone;
    logic rxPending;

    // Transmit shifter, bit 0 is the trailing sentinel
    logic [ByteWidth:0] txShift;
    logic txBoundary;
    // Second filler byte still owed
    logic zeroPending;

    // ======================================================================
    // Receive, debugDi into cmdQueue
    // ======================================================================

    // Sentinel reached the top, eight bits are in
    assign rxDone = rxShift[ByteWidth];
    // Held while debugCs is low, so the write waits too
    assign cmdQueue.wr = rxPending && debugCs;

    always_ff @(posedge debugClk) begin
        if (debugRst) begin
            rxShift <= {{ByteWidth{1'b0}}, 1'b1};
            rxPending <= 1'b0;
        end else if (debugCs) begin
            if (rxDone) begin
                // Nop polls never reach the queue
                rxPending <= (rxShift[ByteWidth-1:0] != CmdNop);
                // Fresh sentinel plus first bit of the next byte
                rxShift <= {{(ByteWidth-1){1'b0}}, 1'b1, debugDi};
            end else begin
                rxPending <= 1'b0;
                rxShift <= {rxShift[ByteWidth-1:0], debugDi};
            end
        end
    end

    // Byte offered to the queue
    // lost if the queue happens to be full
    always_ff @(posedge debugClk) begin
        if (debugCs && rxDone) begin
            cmdQueue.wrData <= rxShift[ByteWidth-1:0];
        end
    end

    // ======================================================================
    // Transmit, replyQueue onto debugDo
    // ======================================================================

    assign debugDo = txShift[ByteWidth];
    assign replyQueue.rdClk = debugClk;

    // Last data bit on debugDo, sentinel right below it
    assign txBoundary = (txShift[ByteWidth-1:0] == {1'b1, {(ByteWidth-1){1'b0}}});
    // Pop on the same edge that loads the head byte
    assign replyQueue.rd = debugCs && txBoundary && !zeroPending;

    always_ff @(posedge debugClk) begin
        if (debugRst) begin
            // Parked on a boundary, first byte loads on the first edge
            txShift <= {1'b0, 1'b1, {(ByteWidth-1){1'b0}}};
            zeroPending <= 1'b0;
        end else if (debugCs) begin
            if (!txBoundary) begin
                txShift <= txShift << 1;
            end else if (zeroPending) begin
                txShift <= {{ByteWidth{1'b0}}, 1'b1};
                zeroPending <= 1'b0;
            end else if (replyQueue.rdOk) begin
                txShift <= {replyQueue.rdData, 1'b1};
            end else begin
                // Nothing queued, send Nop and a zero length
                txShift <= {{ByteWidth{1'b0}}, 1'b1};
                zeroPending <= 1'b1;
            end
        end
    end

endmodule

//--- logic/msgFramer.sv
`timescale 1ns/1ns

module msgFramer import debugPkg::*; (
    input logic clk,
    input logic rst,
    input logic [ByteWidth-1:0] msg,
    input logic [MsgLenWidth-1:0] msgLen,
    output logic msgTrigger,
    byteQueueIf.writer replyQueue
);

    // 0 idle, 1 command byte queued, 2 byte waiting on the FIFO, 3 load payload byte
    logic [1:0] state;
    // Byte in flight ends the reply
    logic lastByte;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= 2'd0;
            replyQueue.wr <= 1'b0;
            msgTrigger <= 1'b0;
            lastByte <= 1'b0;
        end else begin
            // One cycle pulse unless set below
            msgTrigger <= 1'b0;
            case (state)
                2'd0: begin
                    if (msgLen != '0) begin
                        replyQueue.wr <= 1'b1;
                        state <= 2'd1;
                    end
                end
                2'd1: begin
                    // Command byte taken, length byte goes next
                    if (replyQueue.wrOk) begin
                        msgTrigger <= 1'b1;
                        lastByte <= (msgLen == MsgLenWidth'(1));
                        state <= 2'd2;
                    end
                end
                2'd2: begin
                    if (replyQueue.wrOk) begin
                        replyQueue.wr <= 1'b0;
                        state <= lastByte ? 2'd0 : 2'd3;
                    end
                end
                default: begin
                    // Dispatcher has already stepped msg and msgLen here
                    replyQueue.wr <= 1'b1;
                    msgTrigger <= 1'b1;
                    lastByte <= (msgLen == MsgLenWidth'(1));
                    state <= 2'd2;
                end
            endcase
        end
    end

    // Outgoing byte, held while the FIFO is full
    always_ff @(posedge clk) begin
        case (state)
            2'd0: begin
                if (msgLen != '0) begin
                    replyQueue.wrData <= msg;
                end
            end
            2'd1: begin
                if (replyQueue.wrOk) begin
                    replyQueue.wrData <= ByteWidth'(msgLen - 1'b1);
                end
            end
            2'd3: replyQueue.wrData <= msg;
            default: ;
        endcase
    end

endmodule

//--- logic/cmdDispatcher.sv
`timescale 1ns/1ns

module cmdDispatcher import debugPkg::*; (
    input logic clk,
    input logic rst,
    byteQueueIf.reader cmdQueue,
    output logic [ByteWidth-1:0] msg,
    output logic [MsgLenWidth-1:0] msgLen,
    input logic msgTrigger,
    output logic led
);

    // Reply still being handed to the framer
    logic busy;
    logic take;

    // ReadMem source
    logic [ByteWidth-1:0] wordAddr;
    logic hiByte;
    logic [2*ByteWidth-1:0] memWord;

    // Address pattern the memory is filled with
    function automatic logic [2*ByteWidth-1:0] wordFromAddr(input logic [ByteWidth-1:0] addr);
        return {{ByteWidth{1'b0}}, addr};
    endfunction

    assign cmdQueue.rdClk = clk;
    // Pull a command only between replies
    assign cmdQueue.rd = !busy;
    assign take = cmdQueue.rd && cmdQueue.rdOk;
    assign memWord = wordFromAddr(wordAddr);

    // ======================================================================
    // Decode and reply length
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            msgLen <= '0;
            led <= 1'b0;
        end else if (take) begin
            busy <= 1'b1;
            case (cmdQueue.rdData)
                CmdLedOff: begin
                    led <= 1'b0;
                    msgLen <= MsgLenWidth'(1);
                end
                CmdLedOn: begin
                    led <= 1'b1;
                    msgLen <= MsgLenWidth'(1);
                end
                // Command byte plus the pattern payload
                CmdReadMem: msgLen <= MsgLenWidth'(ReadMemBytes + 1);
                // Anything else is echoed, empty payload
                default: msgLen <= MsgLenWidth'(1);
            endcase
        end else if (busy && msgTrigger) begin
            msgLen <= msgLen - 1'b1;
            if (msgLen == MsgLenWidth'(1)) begin
                busy <= 1'b0;
            end
        end
    end

    // ======================================================================
    // Reply bytes
    // ======================================================================

    // Low byte of each word first, then its high byte
    always_ff @(posedge clk) begin
        if (take) begin
            msg <= cmdQueue.rdData;
            wordAddr <= '0;
            hiByte <= 1'b0;
        end else if (busy && msgTrigger) begin
            // Past the end of an echo this is ignored, msgLen is zero by then
            msg <= hiByte ? memWord[2*ByteWidth-1 -: ByteWidth] : memWord[ByteWidth-1:0];
            if (hiByte) begin
                wordAddr <= wordAddr + 1'b1;
            end
            hiByte <= !hiByte;
        end
    end

endmodule

//--- logic/debugTop.sv
`timescale 1ns/1ns

module debugTop import debugPkg::*; (
    input logic clk,
    input logic rst,
    input logic debugRst,
    input logic debugClk,
    input logic debugCs,
    input logic debugDi,
    output logic debugDo,
    output logic led
);

    // Dispatcher to framer
    logic [ByteWidth-1:0] msg;
    logic [MsgLenWidth-1:0] msgLen;
    logic msgTrigger;

    byteQueueIf cmdQueue ();
    byteQueueIf replyQueue ();

    // ======================================================================
    // Queues, clk and rst always belong to the writing side
    // ======================================================================

    // Host commands, written on debugClk
    asyncByteFifo cmdFifo (
        .clk(debugClk),
        .rst(debugRst),
        .debugRst(rst),
        .port(cmdQueue)
    );

    // Replies, written on clk
    asyncByteFifo replyFifo (
        .clk(clk),
        .rst(rst),
        .debugRst(debugRst),
        .port(replyQueue)
    );

    // ======================================================================
    // Link, framer and dispatcher
    // ======================================================================

    serialLink link (
        .debugClk(debugClk),
        .debugRst(debugRst),
        .debugCs(debugCs),
        .debugDi(debugDi),
        .debugDo(debugDo),
        .cmdQueue(cmdQueue.writer),
        .replyQueue(replyQueue.reader)
    );

    msgFramer framer (
        .clk(clk),
        .rst(rst),
        .msg(msg),
        .msgLen(msgLen),
        .msgTrigger(msgTrigger),
        .replyQueue(replyQueue.writer)
    );

    cmdDispatcher dispatcher (
        .clk(clk),
        .rst(rst),
        .cmdQueue(cmdQueue.reader),
        .msg(msg),
        .msgLen(msgLen),
        .msgTrigger(msgTrigger),
        .led(led)
    );

endmodule

//--- test/debugTb_assert.sv
`timescale 1ns/1ns

module debugTbAssert import debugPkg::*; (
    input logic clk,
    input logic rst,
    input logic [MsgLenWidth-1:0] msgLen,
    input logic msgTrigger,
    input logic wr,
    input logic wrOk,
    input logic [ByteWidth-1:0] wrData
);

    // Failed assertions so far, watched from the testbench top
    int unsigned failCount = 0;

    // ======================================================================
    // Framer checks
    // ======================================================================

    // Write blocked by a full FIFO keeps its request and its byte
    holdOnFull: assert property (@(posedge clk) disable iff (rst)
        wr && !wrOk |=> wr && $stable(wrData))
        else begin
            $error("framer changed a write that the full FIFO had blocked");
            failCount++;
        end

    // Trigger is one cycle wide
    singlePulse: assert property (@(posedge clk) disable iff (rst)
        msgTrigger |=> !msgTrigger)
        else begin
            $error("msgTrigger stayed high for more than one cycle");
            failCount++;
        end

    // Only while a reply is still open
    triggerInReply: assert property (@(posedge clk) disable iff (rst)
        msgTrigger |-> msgLen != '0)
        else begin
            $error("msgTrigger fired with msgLen at zero");
            failCount++;
        end

endmodule

//--- test/debugTb.sv
`timescale 1ns/1ns

module debugTb import debugPkg::*; ();

    typedef logic [ByteWidth-1:0] byteList[$];

    // Wait limits in debugClk cycles and in polled bytes
    localparam int CsTimeout = 40;
    localparam int ByteTimeout = 100;
    localparam int ReplyTimeoutBytes = 250;

    logic clk;
    logic rst;
    logic debugRst;
    logic debugClk;
    logic debugCs;
    logic debugDi;
    logic debugDo;
    logic led;

    // Bytes seen on debugDo and commands still owed a reply
    logic [ByteWidth-1:0] rxBytes[$];
    logic [ByteWidth-1:0] sentCmds[$];
    int commandsSent = 0;
    int repliesChecked = 0;
    logic inReply = 1'b0;

    debugTop UUT (
        .clk(clk),
        .rst(rst),
        .debugRst(debugRst),
        .debugClk(debugClk),
        .debugCs(debugCs),
        .debugDi(debugDi),
        .debugDo(debugDo),
        .led(led)
    );

    bind msgFramer debugTbAssert framerChecks (
        .clk(clk),
        .rst(rst),
        .msgLen(msgLen),
        .msgTrigger(msgTrigger),
        .wr(replyQueue.wr),
        .wrOk(replyQueue.wrOk),
        .wrData(replyQueue.wrData)
    );

    // System clock of 20 ns and link clock of 100 ns
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        debugClk = 1'b0;
        forever #50 debugClk = ~debugClk;
    end

    // ======================================================================
    // Reference model and compare tasks
    // ======================================================================

    // Command byte, payload length, payload
    function automatic byteList expectedReply(input logic [ByteWidth-1:0] cmd);
        byteList reply;
        reply.push_back(cmd);
        if (cmd == CmdReadMem) begin
            reply.push_back(ByteWidth'(ReadMemBytes));
            // Even bytes hold the word address and odd bytes its zero high half
            for (int k = 0; k < ReadMemBytes; k++) begin
                reply.push_back((k % 2 == 0) ? ByteWidth'(k / 2) : '0);
            end
        end else begin
            reply.push_back('0);
        end
        return reply;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic checkByte(input string name, input logic [ByteWidth-1:0] actual,
                             input logic [ByteWidth-1:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("FAILED at %0t: %s = %02h, expected %02h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic checkLed(input logic expected);
        if (led !== expected) begin
            abortRun($sformatf("FAILED at %0t: led = %0b, expected %0b", $time, led, expected));
        end
    endtask

    // Assertion failures end the run at once
    always @(posedge clk) begin
        if (UUT.framer.framerChecks.failCount != 0) begin
            abortRun("an assertion on msgFramer failed");
        end
    end

    // ======================================================================
    // Host side of the link
    // ======================================================================

    // MSB first with each bit sampled by the DUT on the next debugClk rise
    task automatic sendByte(input logic [ByteWidth-1:0] value);
        for (int i = ByteWidth - 1; i >= 0; i--) begin
            debugDi <= value[i];
            @(posedge debugClk);
        end
    endtask

    task automatic sendCommand(input logic [ByteWidth-1:0] cmd);
        sentCmds.push_back(cmd);
        commandsSent++;
        sendByte(cmd);
    endtask

    // Poll with Nop until every command has its reply
    task automatic awaitReplies();
        int polls;
        polls = 0;
        while (repliesChecked < commandsSent) begin
            if (polls >= ReplyTimeoutBytes) begin
                abortRun("timed out waiting for replies from the DUT");
            end
            sendByte(CmdNop);
            polls++;
        end
    endtask

    task automatic nextRxByte(output logic [ByteWidth-1:0] value);
        int waited;
        waited = 0;
        while (rxBytes.size() == 0) begin
            if (waited >= ByteTimeout) begin
                abortRun("no byte came back on debugDo");
            end
            @(posedge debugClk);
            waited++;
        end
        value = rxBytes.pop_front();
    endtask

    // Byte frames start on the first edge that sees debugCs high
    initial begin : receiveBytes
        logic [ByteWidth-1:0] shift;
        int waited;
        waited = 0;
        @(posedge debugClk);
        while (debugCs !== 1'b1) begin
            if (waited >= CsTimeout) begin
                abortRun("debugCs never went high");
            end
            @(posedge debugClk);
            waited++;
        end
        // debugDo settles after each rise so it is read at the fall
        forever begin
            for (int i = ByteWidth - 1; i >= 0; i--) begin
                @(negedge debugClk);
                shift[i] = debugDo;
            end
            rxBytes.push_back(shift);
        end
    end

    // Filler zeros are skipped until a non-zero byte opens the next reply
    initial begin : compareReplies
        byteList expected;
        logic [ByteWidth-1:0] got;
        logic [ByteWidth-1:0] cmd;
        int idx;
        idx = 0;
        forever begin
            nextRxByte(got);
            if (!inReply && got != CmdNop) begin
                if (sentCmds.size() == 0) begin
                    abortRun($sformatf("reply byte %02h arrived with no command sent", got));
                end else begin
                    cmd = sentCmds.pop_front();
                    expected = expectedReply(cmd);
                    inReply = 1'b1;
                    idx = 0;
                end
            end
            if (inReply) begin
                checkByte($sformatf("debugDo byte %0d of reply to %02h", idx, cmd),
                          got, expected[idx]);
                idx++;
                if (idx == expected.size()) begin
                    inReply = 1'b0;
                    repliesChecked++;
                end
            end
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================

    initial begin : hostSequence
        logic [ByteWidth-1:0] cmd;
        logic expectedLed;
        int burstLen;
        int pick;

        rst = 1'b1;
        debugRst = 1'b1;
        debugCs = 1'b0;
        debugDi = 1'b0;
        expectedLed = 1'b0;
        void'($urandom(32'haa08_d219));

        fork
            begin
                repeat (10) @(posedge clk);
                rst <= 1'b0;
            end
            begin
                repeat (10) @(posedge debugClk);
                debugRst <= 1'b0;
            end
        join

        // Select stays high for the whole run
        @(posedge debugClk);
        debugCs <= 1'b1;
        checkLed(1'b0);
        repeat (6) sendByte(CmdNop);

        sendCommand(CmdLedOn);
        awaitReplies();
        checkLed(1'b1);
        sendCommand(CmdLedOff);
        awaitReplies();
        checkLed(1'b0);

        // Unknown command echoed
        sendCommand(8'h55);
        awaitReplies();
        repeat (4) sendByte(CmdNop);

        sendCommand(CmdReadMem);
        awaitReplies();

        // Random bursts that each drain before the next
        repeat (2) begin
            burstLen = 1 + int'($urandom % 6);
            for (int n = 0; n < burstLen; n++) begin
                pick = int'($urandom % 4);
                case (pick)
                    0: cmd = CmdLedOff;
                    1: cmd = CmdLedOn;
                    2: cmd = CmdReadMem;
                    default: cmd = ByteWidth'(1 + $urandom % 255);
                endcase
                if (cmd == CmdLedOn) begin
                    expectedLed = 1'b1;
                end else if (cmd == CmdLedOff) begin
                    expectedLed = 1'b0;
                end
                sendCommand(cmd);
            end
            awaitReplies();
            checkLed(expectedLed);
        end

        // Any stray reply on the quiet link has no command left to match
        repeat (8) sendByte(CmdNop);
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- project.f
logic/debugPkg.sv
logic/byteQueueIf.sv
logic/asyncByteFifo.sv
logic/serialLink.sv
logic/msgFramer.sv
logic/cmdDispatcher.sv
logic/debugTop.sv
test/debugTb_assert.sv
test/debugTb.sv

//--- run.sh
#!/bin/sh
# Build and run the debug port testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module debugTb -f project.f
status=0
./obj_dir/VdebugTb +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Result: FAILED" sim.log || [ "$status" -ne 0 ]; then
    exit 1
fi
